// ==== hdl/exu_op_pkg.sv ====
/* operation encodings, the two-view operation union,
   and the issue and result structs of an execution lane */
package exu_op_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 3;

    // integer ALU functions
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_fn_e;

    // access size of a load or store
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic    is_mem;
        alu_fn_e fn;
    } exu_alu_op_t;

    typedef struct packed {
        logic      is_mem;
        logic      is_store;
        logic      is_unsigned;
        mem_size_e size;
    } exu_mem_op_t;

    // top bit is_mem selects which view is valid
    typedef union packed {
        exu_alu_op_t alu;
        exu_mem_op_t mem;
    } exu_op_u;

    // for memory ops op1 is the base and op2 the offset
    typedef struct packed {
        exu_op_u                op;
        logic [XLEN-1:0]        op1;
        logic [XLEN-1:0]        op2;
        logic [XLEN-1:0]        sdata;
        logic [REG_ADDR_W-1:0]  rd;
        logic [COMMIT_ID_W-1:0] commit_id;
    } exu_issue_t;

    typedef struct packed {
        logic [XLEN-1:0]        wdata;
        logic                   reg_we;
        logic [REG_ADDR_W-1:0]  rd;
        logic [COMMIT_ID_W-1:0] commit_id;
    } exu_result_t;

endpackage

// ==== hdl/dmem_bus_pkg.sv ====
/* widths, depth, and the request and response structs
   of the shared data RAM bus */
package dmem_bus_pkg;

    localparam int DMEM_DEPTH  = 64;
    localparam int DMEM_IDX_W  = 6;
    localparam int BYTE_LANES  = 4;
    localparam int DMEM_DATA_W = 32;

    // word index, byte-lane write mask and write data
    typedef struct packed {
        logic [DMEM_IDX_W-1:0]  widx;
        logic                   we;
        logic [BYTE_LANES-1:0]  wmask;
        logic [DMEM_DATA_W-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic [DMEM_DATA_W-1:0] rdata;
    } dmem_rsp_t;

endpackage

// ==== hdl/exu_alu.sv ====
/* combinational integer ALU, also used as the load/store address adder */
`timescale 1ns/10ps

module exu_alu (
    input  exu_op_pkg::alu_fn_e            fn_i,
    input  logic [exu_op_pkg::XLEN-1:0]    a_i,
    input  logic [exu_op_pkg::XLEN-1:0]    b_i,
    output logic [exu_op_pkg::XLEN-1:0]    y_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shift amount is the low 5 bits of b
    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (fn_i)
            exu_op_pkg::ALU_ADD: begin
                y_o = a_i + b_i;
            end
            exu_op_pkg::ALU_SUB: begin
                y_o = a_i - b_i;
            end
            exu_op_pkg::ALU_AND: begin
                y_o = a_i & b_i;
            end
            exu_op_pkg::ALU_OR: begin
                y_o = a_i | b_i;
            end
            exu_op_pkg::ALU_XOR: begin
                y_o = a_i ^ b_i;
            end
            exu_op_pkg::ALU_SLT: begin
                y_o = {{(exu_op_pkg::XLEN-1){1'b0}}, lt_signed};
            end
            exu_op_pkg::ALU_SLTU: begin
                y_o = {{(exu_op_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            exu_op_pkg::ALU_SLL: begin
                y_o = a_i << shamt;
            end
            exu_op_pkg::ALU_SRL: begin
                y_o = a_i >> shamt;
            end
            exu_op_pkg::ALU_SRA: begin
                y_o = $signed(a_i) >>> shamt;
            end
            default: begin
                y_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/exu_lane.sv ====
/* one execution lane: issue handshake, ALU execution, memory sequencing
   over the shared bus, store masking and load extraction */
`timescale 1ns/10ps

module exu_lane (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      req_i,
    input  exu_op_pkg::exu_issue_t    issue_i,
    output logic                      ack_o,
    output exu_op_pkg::exu_result_t   result_o,
    output logic                      bus_req_o,
    output dmem_bus_pkg::dmem_req_t   bus_o,
    input  logic                      bus_ack_i,
    input  dmem_bus_pkg::dmem_rsp_t   bus_rsp_i
);

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_MEM_WAIT = 2'd1,
        ST_DONE     = 2'd2
    } lane_state_e;

    lane_state_e                    state_q;
    logic                           ack_q;
    exu_op_pkg::exu_issue_t         issue_q;
    logic [exu_op_pkg::XLEN-1:0]    rdata_q;
    exu_op_pkg::exu_result_t        result_q;
    exu_op_pkg::exu_result_t        result_d;

    exu_op_pkg::alu_fn_e            alu_fn;
    logic [exu_op_pkg::XLEN-1:0]    alu_y;
    logic                           is_mem;
    logic [1:0]                     byte_off;
    logic [dmem_bus_pkg::BYTE_LANES-1:0] store_mask;
    logic [exu_op_pkg::XLEN-1:0]    load_shift;
    logic [exu_op_pkg::XLEN-1:0]    load_data;

    // memory ops borrow the ALU adder for base + offset
    assign is_mem   = issue_q.op.mem.is_mem;
    assign alu_fn   = is_mem ? exu_op_pkg::ALU_ADD : issue_q.op.alu.fn;
    assign byte_off = alu_y[1:0];

    exu_alu u_alu (
        .fn_i (alu_fn),
        .a_i  (issue_q.op1),
        .b_i  (issue_q.op2),
        .y_o  (alu_y)
    );

    always_comb begin
        case (issue_q.op.mem.size)
            exu_op_pkg::MEM_BYTE: store_mask = 4'b0001 << byte_off;
            exu_op_pkg::MEM_HALF: store_mask = 4'b0011 << byte_off;
            default:              store_mask = 4'b1111;
        endcase
    end

    // request stays up until the RAM answers
    assign bus_req_o   = (state_q == ST_MEM_WAIT);
    assign bus_o.widx  = alu_y[dmem_bus_pkg::DMEM_IDX_W+1:2];
    assign bus_o.we    = issue_q.op.mem.is_store;
    assign bus_o.wmask = store_mask;
    assign bus_o.wdata = issue_q.sdata << {byte_off, 3'b000};

    // addressed byte or half moved down to bit 0
    assign load_shift = rdata_q >> {byte_off, 3'b000};

    always_comb begin
        case (issue_q.op.mem.size)
            exu_op_pkg::MEM_BYTE: begin
                load_data = {{(exu_op_pkg::XLEN-8){load_shift[7] & ~issue_q.op.mem.is_unsigned}},
                             load_shift[7:0]};
            end
            exu_op_pkg::MEM_HALF: begin
                load_data = {{(exu_op_pkg::XLEN-16){load_shift[15] & ~issue_q.op.mem.is_unsigned}},
                             load_shift[15:0]};
            end
            default: begin
                load_data = load_shift;
            end
        endcase
    end

    always_comb begin
        result_d.rd        = issue_q.rd;
        result_d.commit_id = issue_q.commit_id;
        result_d.reg_we    = !(is_mem && issue_q.op.mem.is_store);
        if (!is_mem) begin
            result_d.wdata = alu_y;
        end else if (issue_q.op.mem.is_store) begin
            result_d.wdata = '0;
        end else begin
            result_d.wdata = load_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        state_q <= issue_i.op.mem.is_mem ? ST_MEM_WAIT : ST_DONE;
                    end
                end
                ST_MEM_WAIT: begin
                    if (bus_ack_i) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // hold ack until the requester lets go
                    if (!ack_q) begin
                        ack_q <= 1'b1;
                    end else if (!req_i) begin
                        ack_q   <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req_i) begin
            issue_q <= issue_i;
        end
        if (state_q == ST_MEM_WAIT && bus_ack_i) begin
            rdata_q <= bus_rsp_i.rdata;
        end
        if (state_q == ST_DONE && !ack_q) begin
            result_q <= result_d;
        end
    end

    assign ack_o    = ack_q;
    assign result_o = result_q;

    // requester keeps the op steady until the lane answers
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (req_i && !ack_o) ##1 (req_i && !ack_o) |-> $stable(issue_i));

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_q == ST_MEM_WAIT) |->
            !((issue_q.op.mem.size == exu_op_pkg::MEM_HALF && alu_y[0]) ||
              (issue_q.op.mem.size == exu_op_pkg::MEM_WORD && alu_y[1:0] != 2'b00)));

endmodule

// ==== hdl/dmem_arbiter.sv ====
/* round-robin arbiter sharing one four-phase RAM port between two lanes */
`timescale 1ns/10ps

module dmem_arbiter (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      req0_i,
    input  dmem_bus_pkg::dmem_req_t   bus0_i,
    output logic                      ack0_o,
    input  logic                      req1_i,
    input  dmem_bus_pkg::dmem_req_t   bus1_i,
    output logic                      ack1_o,
    output dmem_bus_pkg::dmem_rsp_t   rsp_o,
    output logic                      ram_req_o,
    output dmem_bus_pkg::dmem_req_t   ram_o,
    input  logic                      ram_ack_i,
    input  dmem_bus_pkg::dmem_rsp_t   ram_rsp_i
);

    logic owner_vld_q;
    logic owner_q;
    logic last_q;
    logic owner_req;
    logic grant;

    assign owner_req = owner_q ? req1_i : req0_i;

    // on a tie the lane not served last wins
    assign grant = (req0_i && req1_i) ? ~last_q : req1_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            owner_vld_q <= 1'b0;
            owner_q     <= 1'b0;
            // lane 0 goes first after reset
            last_q      <= 1'b1;
        end else if (!owner_vld_q) begin
            if (req0_i || req1_i) begin
                owner_vld_q <= 1'b1;
                owner_q     <= grant;
                last_q      <= grant;
            end
        end else if (!owner_req && !ram_ack_i) begin
            // exchange with the RAM fully closed
            owner_vld_q <= 1'b0;
        end
    end

    assign ram_req_o = owner_vld_q && owner_req;
    assign ram_o     = owner_q ? bus1_i : bus0_i;
    assign ack0_o    = owner_vld_q && !owner_q && ram_ack_i;
    assign ack1_o    = owner_vld_q && owner_q && ram_ack_i;
    assign rsp_o     = ram_rsp_i;

    // RAM answers only inside a grant, and the owner holds while it does
    assert property (@(posedge clk) disable iff (!rst_n_i)
        ram_ack_i |-> (owner_vld_q && $stable(owner_q)));

endmodule

// ==== hdl/dmem_ram.sv ====
/* byte-masked word RAM with registered read behind a four-phase port */
`timescale 1ns/10ps

module dmem_ram (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      req_i,
    input  dmem_bus_pkg::dmem_req_t   bus_i,
    output logic                      ack_o,
    output dmem_bus_pkg::dmem_rsp_t   rsp_o
);

    logic [dmem_bus_pkg::DMEM_DATA_W-1:0] mem_q [dmem_bus_pkg::DMEM_DEPTH];
    logic [dmem_bus_pkg::DMEM_DATA_W-1:0] rdata_q;
    logic                                 ack_q;

    initial begin
        for (int i = 0; i < dmem_bus_pkg::DMEM_DEPTH; i++) begin
            mem_q[i] = '0;
        end
    end

    // ack follows req by one cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_i;
        end
    end

    // access happens once, on the edge that raises ack
    always_ff @(posedge clk) begin
        if (req_i && !ack_q) begin
            rdata_q <= mem_q[bus_i.widx];
            if (bus_i.we) begin
                for (int b = 0; b < dmem_bus_pkg::BYTE_LANES; b++) begin
                    if (bus_i.wmask[b]) begin
                        mem_q[bus_i.widx][b*8 +: 8] <= bus_i.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign ack_o       = ack_q;
    assign rsp_o.rdata = rdata_q;

endmodule

// ==== hdl/exu_dual.sv ====
/* two-lane execution unit: both lanes, the RAM arbiter and the data RAM */
`timescale 1ns/10ps

module exu_dual (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      lane0_req_i,
    input  exu_op_pkg::exu_issue_t    lane0_issue_i,
    output logic                      lane0_ack_o,
    output exu_op_pkg::exu_result_t   lane0_result_o,
    input  logic                      lane1_req_i,
    input  exu_op_pkg::exu_issue_t    lane1_issue_i,
    output logic                      lane1_ack_o,
    output exu_op_pkg::exu_result_t   lane1_result_o
);

    logic                      lane0_bus_req;
    logic                      lane0_bus_ack;
    dmem_bus_pkg::dmem_req_t   lane0_bus;
    logic                      lane1_bus_req;
    logic                      lane1_bus_ack;
    dmem_bus_pkg::dmem_req_t   lane1_bus;
    dmem_bus_pkg::dmem_rsp_t   lane_rsp;

    logic                      ram_req;
    logic                      ram_ack;
    dmem_bus_pkg::dmem_req_t   ram_bus;
    dmem_bus_pkg::dmem_rsp_t   ram_rsp;

    exu_lane u_lane0 (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .req_i     (lane0_req_i),
        .issue_i   (lane0_issue_i),
        .ack_o     (lane0_ack_o),
        .result_o  (lane0_result_o),
        .bus_req_o (lane0_bus_req),
        .bus_o     (lane0_bus),
        .bus_ack_i (lane0_bus_ack),
        .bus_rsp_i (lane_rsp)
    );

    exu_lane u_lane1 (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .req_i     (lane1_req_i),
        .issue_i   (lane1_issue_i),
        .ack_o     (lane1_ack_o),
        .result_o  (lane1_result_o),
        .bus_req_o (lane1_bus_req),
        .bus_o     (lane1_bus),
        .bus_ack_i (lane1_bus_ack),
        .bus_rsp_i (lane_rsp)
    );

    // both load/store paths merge onto one RAM port
    dmem_arbiter u_arbiter (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .req0_i    (lane0_bus_req),
        .bus0_i    (lane0_bus),
        .ack0_o    (lane0_bus_ack),
        .req1_i    (lane1_bus_req),
        .bus1_i    (lane1_bus),
        .ack1_o    (lane1_bus_ack),
        .rsp_o     (lane_rsp),
        .ram_req_o (ram_req),
        .ram_o     (ram_bus),
        .ram_ack_i (ram_ack),
        .ram_rsp_i (ram_rsp)
    );

    dmem_ram u_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (ram_req),
        .bus_i   (ram_bus),
        .ack_o   (ram_ack),
        .rsp_o   (ram_rsp)
    );

endmodule

// ==== tb/tb_exu_dual.sv ====
/* testbench for the two-lane execution unit with record-driven
   four-phase issue on both lanes and result checks */
`timescale 1ns/10ps

module tb_exu_dual;

    localparam int          REC_W    = 8;
    localparam int          MAX_REC  = 64;
    localparam logic [31:0] END_MARK = 32'h0000_00ff;

    logic                    clk;
    logic                    rst_n;
    logic                    lane0_req;
    logic                    lane1_req;
    exu_op_pkg::exu_issue_t  lane0_issue;
    exu_op_pkg::exu_issue_t  lane1_issue;
    logic                    lane0_ack;
    logic                    lane1_ack;
    exu_op_pkg::exu_result_t lane0_result;
    exu_op_pkg::exu_result_t lane1_result;

    logic [31:0] tdata [MAX_REC*REC_W];
    logic [31:0] rng_state;
    int          n_rec;
    int          cycle_cnt;
    int          cycle_limit;

    exu_dual DUT (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .lane0_req_i    (lane0_req),
        .lane0_issue_i  (lane0_issue),
        .lane0_ack_o    (lane0_ack),
        .lane0_result_o (lane0_result),
        .lane1_req_i    (lane1_req),
        .lane1_issue_i  (lane1_issue),
        .lane1_ack_o    (lane1_ack),
        .lane1_result_o (lane1_result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic end_with_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            end_with_failure($sformatf("Fail at %0d ns: %s got %0h expected %0h",
                                       $time, name, got, exp));
        end
    endtask

    // watchdog with a limit set once the records are counted
    initial begin
        cycle_cnt = 0;
        @(posedge clk);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        end_with_failure($sformatf("timeout: tests not done within %0d cycles", cycle_limit));
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic ack_of(input int lane);
        return (lane == 0) ? lane0_ack : lane1_ack;
    endfunction

    function automatic logic req_of(input int lane);
        return (lane == 0) ? lane0_req : lane1_req;
    endfunction

    function automatic exu_op_pkg::exu_result_t result_of(input int lane);
        return (lane == 0) ? lane0_result : lane1_result;
    endfunction

    task automatic drive_lane(input int lane, input logic req,
                              input exu_op_pkg::exu_issue_t issue);
        if (lane == 0) begin
            lane0_req   <= req;
            lane0_issue <= issue;
        end else begin
            lane1_req   <= req;
            lane1_issue <= issue;
        end
    endtask

    // one full four-phase exchange on one lane
    task automatic run_lane(input int lane, input int rec, input int idle, input int hold,
                            input logic other_busy);
        exu_op_pkg::exu_issue_t  issue;
        exu_op_pkg::exu_result_t res;
        exu_op_pkg::exu_result_t held;
        logic [31:0]             exp_wdata;
        logic                    exp_we;
        int                      b;
        string                   pfx;
        b               = rec * REC_W;
        pfx             = $sformatf("lane%0d_", lane);
        issue.op        = tdata[b+1][4:0];
        issue.op1       = tdata[b+2];
        issue.op2       = tdata[b+3];
        issue.sdata     = tdata[b+4];
        issue.rd        = tdata[b+5][4:0];
        issue.commit_id = tdata[b+6][2:0];
        exp_wdata       = tdata[b+7];
        // only stores leave the register file alone
        exp_we          = !(tdata[b+1][4] && tdata[b+1][3]);

        repeat (idle) @(posedge clk);
        @(posedge clk);
        drive_lane(lane, 1'b1, issue);
        do begin
            @(negedge clk);
        end while (!ack_of(lane));
        res = result_of(lane);
        check_val({pfx, "result_o.wdata"}, 64'(res.wdata), 64'(exp_wdata));
        check_val({pfx, "result_o.reg_we"}, 64'(res.reg_we), 64'(exp_we));
        check_val({pfx, "result_o.rd"}, 64'(res.rd), 64'(issue.rd));
        check_val({pfx, "result_o.commit_id"}, 64'(res.commit_id), 64'(issue.commit_id));
        if (other_busy) begin
            // memory op on the other lane still in flight
            check_val($sformatf("lane%0d_req_i", 1 - lane), 64'(req_of(1 - lane)), 64'd1);
            check_val($sformatf("lane%0d_ack_o", 1 - lane), 64'(ack_of(1 - lane)), 64'd0);
        end

        // ack and result held while req stays up
        repeat (hold) begin
            @(negedge clk);
            held = result_of(lane);
            check_val({pfx, "ack_o"}, 64'(ack_of(lane)), 64'd1);
            check_val({pfx, "result_o"}, 64'(held), 64'(res));
        end
        @(posedge clk);
        drive_lane(lane, 1'b0, issue);
        @(negedge clk);
        check_val({pfx, "ack_o"}, 64'(ack_of(lane)), 64'd1);
        while (ack_of(lane)) begin
            @(negedge clk);
        end
    endtask

    initial begin
        int   r0;
        int   r1;
        int   idle0;
        int   idle1;
        int   hold0;
        int   hold1;
        logic mem0;
        logic mem1;

        rst_n       = 1'b0;
        lane0_req   = 1'b0;
        lane1_req   = 1'b0;
        lane0_issue = '0;
        lane1_issue = '0;
        rng_state   = 32'd82;
        cycle_limit = 100;

        $readmemh("tb/exu_testdata.hex", tdata);
        n_rec = 0;
        while (n_rec < MAX_REC && tdata[n_rec*REC_W] != END_MARK) begin
            n_rec++;
        end
        if (n_rec == MAX_REC || n_rec == 0 || (n_rec % 2) != 0) begin
            end_with_failure("test data needs an even number of records and an end marker");
        end
        cycle_limit = 20 * n_rec + 100;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("lane0_ack_o", 64'(lane0_ack), 64'd0);
        check_val("lane1_ack_o", 64'(lane1_ack), 64'd0);

        for (int p = 0; p < n_rec / 2; p++) begin
            r0 = 2 * p;
            r1 = 2 * p + 1;
            if (tdata[r0*REC_W] != 32'd0 || tdata[r1*REC_W] != 32'd1) begin
                end_with_failure($sformatf("records %0d and %0d are not lane 0 then lane 1",
                                           r0, r1));
            end
            mem0  = tdata[r0*REC_W+1][4];
            mem1  = tdata[r1*REC_W+1][4];
            idle0 = int'(xorshift32() & 32'd3);
            idle1 = int'(xorshift32() & 32'd3);
            hold0 = int'(xorshift32() & 32'd3);
            hold1 = int'(xorshift32() & 32'd3);
            // an ALU op beside a memory op starts together with it
            if (mem0 != mem1) begin
                idle0 = 0;
                idle1 = 0;
            end
            fork
                run_lane(0, r0, idle0, hold0, mem1 && !mem0);
                run_lane(1, r1, idle1, hold1, mem0 && !mem1);
            join
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== exu_dual.f ====
hdl/exu_op_pkg.sv
hdl/dmem_bus_pkg.sv
hdl/exu_alu.sv
hdl/exu_lane.sv
hdl/dmem_arbiter.sv
hdl/dmem_ram.sv
hdl/exu_dual.sv
tb/tb_exu_dual.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f exu_dual.f \
    --top-module tb_exu_dual -o sim_exu_dual &&
./obj_dir/sim_exu_dual || exit 1

// ==== tb/exu_testdata.hex ====
// columns: lane op op1 op2 sdata rd commit_id expected_wdata
// op is {is_mem, fn} or {is_mem, is_store, is_unsigned, size}; lane ff ends the list
// ALU functions
0 00 00000005 00000007 00000000 01 0 0000000c
1 01 00000005 00000007 00000000 02 1 fffffffe
0 02 f0f01234 0ff0ff00 00000000 03 2 00f01200
1 03 f0f00000 00001234 00000000 04 3 f0f01234
0 04 aaaa5555 ffff0000 00000000 05 4 55555555
1 05 ffffffff 00000001 00000000 06 5 00000001
0 06 ffffffff 00000001 00000000 07 6 00000000
1 07 00000001 00000025 00000000 08 7 00000020
0 08 80000000 00000004 00000000 09 0 08000000
1 09 80000000 00000004 00000000 0a 1 f8000000
0 05 00000001 ffffffff 00000000 0b 2 00000000
1 06 00000001 ffffffff 00000000 0c 3 00000001
// word stores and loads on both lanes at once
0 1a 00000040 00000000 11223344 0d 4 00000000
1 1a 00000080 00000004 aabbccdd 0e 5 00000000
0 12 00000080 00000004 00000000 0f 6 aabbccdd
1 12 00000040 00000000 00000000 10 7 11223344
// sb and sh merge into the stored words
0 18 00000040 00000001 000000ee 11 0 00000000
1 19 00000080 00000006 00009988 12 1 00000000
0 12 00000040 00000000 00000000 13 2 1122ee44
1 12 00000084 00000000 00000000 14 3 9988ccdd
// sign and zero extension of bytes and halves
0 10 00000040 00000001 00000000 15 4 ffffffee
1 14 00000041 00000000 00000000 16 5 000000ee
0 11 00000080 00000006 00000000 17 6 ffff9988
1 15 00000086 00000000 00000000 18 7 00009988
0 10 00000043 00000000 00000000 19 0 00000011
1 11 00000084 00000000 00000000 1a 1 ffffccdd
// ALU op beside a memory op
0 1a 000000f0 0000000c deadbeef 1b 2 00000000
1 00 7fffffff 00000001 00000000 1c 3 80000000
0 09 ffff0000 00000108 00000000 1d 4 ffffff00
1 12 000000fc 00000000 00000000 1e 5 deadbeef
// top and bottom of the RAM
0 14 00000000 000000ff 00000000 1f 6 000000de
1 18 00000000 00000000 000000a5 01 7 00000000
0 12 00000000 00000000 00000000 02 0 000000a5
1 15 00000010 00000002 00000000 03 1 00000000
ff 00 00000000 00000000 00000000 00 0 00000000
